// ==== include/igr_shim_params.svh ====
`ifndef IGR_SHIM_PARAMS_SVH
`define IGR_SHIM_PARAMS_SVH

// --------------------------------------------------
// datapath geometry
// --------------------------------------------------

// bits per data word
`define IGR_WORD_W 32

// words per flit, and per packed segment
`define IGR_LANES 8

// logical ports carried on one epl link
`define IGR_PORTS 4

// width of the start-of-frame timestamp
`define IGR_TS_W 16

`endif

// ==== source/igr_shim_pkg.sv ====
`include "igr_shim_params.svh"

package igr_shim_pkg;

  // --------------------------------------------------
  // basic fields
  // --------------------------------------------------

  typedef logic [`IGR_WORD_W-1:0] word_t;

  // lane index within a flit
  typedef logic [$clog2(`IGR_LANES)-1:0] lane_t;

  // word count, 0 up to a full flit
  typedef logic [$clog2(`IGR_LANES):0] cnt_t;

  // --------------------------------------------------
  // metadata, one word read two ways
  // --------------------------------------------------

  // start view, valid on a start flit
  typedef struct packed {
    logic [2:0]           tc;
    logic [`IGR_TS_W-1:0] ts;
    logic                 rsvd;
  } md_sop_t;

  // end view, valid on an end flit
  typedef struct packed {
    logic        err;
    logic [13:0] byte_len;
    logic [4:0]  rsvd;
  } md_eop_t;

  typedef union packed {
    md_sop_t sop;
    md_eop_t eop;
  } epl_md_u;

  // --------------------------------------------------
  // flits and segments
  // --------------------------------------------------

  typedef struct packed {
    word_t [`IGR_LANES-1:0]        words;
    logic [`IGR_LANES-1:0]         valid_mask;
    logic [$clog2(`IGR_PORTS)-1:0] port;
    logic                          sop;
    logic                          eop;
    epl_md_u                       md;
  } epl_flit_t;

  // flit after compaction, first valid word in lane 0
  typedef struct packed {
    word_t [`IGR_LANES-1:0] words;
    cnt_t                   count;
    logic [`IGR_PORTS-1:0]  port_oh;
    logic                   sop;
    logic                   eop;
    epl_md_u                md;
  } rx_flit_t;

  typedef struct packed {
    word_t [`IGR_LANES-1:0] words;
    cnt_t                   count;
    logic                   sop;
    logic                   eop;
    epl_md_u                md;
  } shim_seg_t;

  typedef enum logic [1:0] {
    IDLE,
    FRAME,
    FLUSH
  } frame_state_t;

endpackage

// ==== source/igr_shim_rx_stage.sv ====
`timescale 1ns/1ps
`include "igr_shim_params.svh"

module igr_shim_rx_stage (
  input  logic                     cclk,
  input  logic                     rst,
  input  igr_shim_pkg::epl_flit_t  i_flit,
  input  logic                     i_flit_v,
  output igr_shim_pkg::rx_flit_t   o_rx,
  output logic                     o_rx_v
);
  import igr_shim_pkg::*;

  epl_flit_t s1q_flit;
  lane_t     first_lane;
  cnt_t      lane_cnt;

  // --------------------------------------------------
  // s1 input register
  // --------------------------------------------------

  // the link cannot be stalled, so the flit is always captured
  always_ff @(posedge cclk) s1q_flit <= i_flit;

  always_ff @(posedge cclk) begin
    if (rst) begin
      o_rx_v <= 1'b0;
    end else begin
      o_rx_v <= i_flit_v;
    end
  end

  // --------------------------------------------------
  // compaction and port decode
  // --------------------------------------------------

  always_comb begin
    // lowest set mask bit marks the start of the run
    first_lane = '0;
    for (int i = `IGR_LANES - 1; i >= 0; i--) begin
      if (s1q_flit.valid_mask[i]) begin
        first_lane = lane_t'(i);
      end
    end

    lane_cnt = '0;
    for (int i = 0; i < `IGR_LANES; i++) begin
      lane_cnt = lane_cnt + cnt_t'(s1q_flit.valid_mask[i]);
    end

    // shift the run down to lane 0, lanes past the end read as zero
    for (int i = 0; i < `IGR_LANES; i++) begin
      o_rx.words[i] = '0;
      if (i + first_lane < `IGR_LANES) begin
        o_rx.words[i] = s1q_flit.words[i + first_lane];
      end
    end

    for (int p = 0; p < `IGR_PORTS; p++) begin
      o_rx.port_oh[p] = (s1q_flit.port == p);
    end

    o_rx.count = lane_cnt;
    o_rx.sop   = s1q_flit.sop;
    o_rx.eop   = s1q_flit.eop;
    o_rx.md    = s1q_flit.md;
  end

endmodule

// ==== source/igr_shim_fill_counter.sv ====
`timescale 1ns/1ps
`include "igr_shim_params.svh"

module igr_shim_fill_counter (
  input  logic                           cclk,
  input  logic                           rst,
  input  logic [$clog2(`IGR_LANES):0]    i_add,
  input  logic                           i_add_en,
  input  logic                           i_clear,
  output logic [$clog2(`IGR_LANES)-1:0]  o_fill,
  output logic [$clog2(`IGR_LANES)+1:0]  o_sum,
  output logic                           o_wrap,
  output logic                           o_residue
);

  typedef logic [$clog2(`IGR_LANES)+1:0] sum_t;

  // --------------------------------------------------
  // occupancy after this flit
  // --------------------------------------------------

  assign o_sum = sum_t'(o_fill) + sum_t'(i_add);

  // a full segment is ready
  assign o_wrap = (o_sum >= `IGR_LANES);

  // words spill past the segment boundary
  assign o_residue = (o_sum > `IGR_LANES);

  // --------------------------------------------------
  // stored fill
  // --------------------------------------------------

  // the fill wraps modulo a segment, a clear wins over an add
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_fill <= '0;
    end else if (i_clear) begin
      o_fill <= '0;
    end else if (i_add_en) begin
      o_fill <= o_sum[$clog2(`IGR_LANES)-1:0];
    end
  end

endmodule

// ==== source/igr_shim_frame_fsm.sv ====
`timescale 1ns/1ps

module igr_shim_frame_fsm (
  input  logic cclk,
  input  logic rst,
  input  logic i_take,
  input  logic i_sop,
  input  logic i_eop,
  input  logic i_wrap,
  input  logic i_residue,
  output logic o_add_en,
  output logic o_emit,
  output logic o_last,
  output logic o_clear
);
  import igr_shim_pkg::*;

  frame_state_t state_q;
  frame_state_t state_d;
  logic         accept;
  logic         end_flit;

  // --------------------------------------------------
  // flit acceptance
  // --------------------------------------------------

  // data only counts inside a frame or on the flit that opens one
  assign accept   = i_take & ((state_q == FRAME) | ((state_q == IDLE) & i_sop));
  assign end_flit = accept & i_eop;

  // --------------------------------------------------
  // next state and controls
  // --------------------------------------------------

  always_comb begin
    state_d  = state_q;
    o_add_en = accept;
    o_emit   = 1'b0;
    o_last   = 1'b0;
    o_clear  = 1'b0;

    case (state_q)
      // a start+end flit from IDLE closes the frame like an end flit in FRAME
      IDLE, FRAME: begin
        if (end_flit) begin
          o_emit = 1'b1;
          if (i_residue) begin
            // full segment now, leftover words go out in the gap cycle
            state_d = FLUSH;
          end else begin
            o_last  = 1'b1;
            o_clear = 1'b1;
            state_d = IDLE;
          end
        end else if (accept) begin
          o_emit  = i_wrap;
          state_d = FRAME;
        end
      end

      // inter-frame gap, the port carries no flit here
      FLUSH: begin
        o_emit  = 1'b1;
        o_last  = 1'b1;
        o_clear = 1'b1;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge cclk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== source/igr_shim_seg_pack.sv ====
`timescale 1ns/1ps
`include "igr_shim_params.svh"

module igr_shim_seg_pack (
  input  logic                           cclk,
  input  logic                           rst,
  input  igr_shim_pkg::rx_flit_t         i_rx,
  input  logic [$clog2(`IGR_LANES)-1:0]  i_fill,
  input  logic [$clog2(`IGR_LANES)+1:0]  i_sum,
  input  logic                           i_add_en,
  input  logic                           i_emit,
  input  logic                           i_last,
  output igr_shim_pkg::shim_seg_t        o_seg,
  output logic                           o_seg_v
);
  import igr_shim_pkg::*;

  // two segments deep, a flit can straddle the boundary
  word_t [2*`IGR_LANES-1:0] stage_q;
  word_t [2*`IGR_LANES-1:0] merged;

  epl_md_u sop_md_q;
  epl_md_u eop_md_q;
  logic    sop_pend_q;
  logic    first_now;
  logic    end_now;
  epl_md_u start_md;
  epl_md_u end_md;
  cnt_t    last_count;

  // --------------------------------------------------
  // merge incoming words at the fill offset
  // --------------------------------------------------

  always_comb begin
    merged = stage_q;
    if (i_add_en) begin
      for (int j = 0; j < `IGR_LANES; j++) begin
        if (j < i_rx.count) begin
          merged[i_fill + j] = i_rx.words[j];
        end
      end
    end
  end

  assign first_now = i_add_en & i_rx.sop;
  assign end_now   = i_add_en & i_rx.eop;

  // same-cycle metadata bypasses the stored copy
  assign start_md = first_now ? i_rx.md : sop_md_q;
  assign end_md   = end_now ? i_rx.md : eop_md_q;

  // last count is the sum on an end flit, the leftover fill on a flush
  assign last_count = i_add_en ? cnt_t'(i_sum) : cnt_t'(i_fill);

  // --------------------------------------------------
  // staging buffer and segment register
  // --------------------------------------------------

  always_ff @(posedge cclk) begin
    if (i_emit) begin
      // upper half drops into the low half
      stage_q[`IGR_LANES-1:0] <= merged[2*`IGR_LANES-1:`IGR_LANES];
    end else begin
      stage_q <= merged;
    end

    if (first_now) begin
      sop_md_q <= i_rx.md;
    end
    if (end_now) begin
      eop_md_q <= i_rx.md;
    end

    if (i_emit) begin
      o_seg.words <= merged[`IGR_LANES-1:0];
      o_seg.count <= i_last ? last_count : cnt_t'(`IGR_LANES);
      o_seg.sop   <= sop_pend_q | first_now;
      o_seg.eop   <= i_last;
      o_seg.md    <= i_last ? end_md : start_md;
    end
  end

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  // sop_pend marks a frame whose first segment is not out yet
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_seg_v    <= 1'b0;
      sop_pend_q <= 1'b0;
    end else begin
      o_seg_v <= i_emit;
      if (i_emit) begin
        sop_pend_q <= 1'b0;
      end else if (first_now) begin
        sop_pend_q <= 1'b1;
      end
    end
  end

endmodule

// ==== source/igr_shim_top.sv ====
`timescale 1ns/1ps
`include "igr_shim_params.svh"

module igr_shim_top (
  input  logic                                      cclk,
  input  logic                                      rst,
  input  igr_shim_pkg::epl_flit_t                   i_flit,
  input  logic                                      i_flit_v,
  output igr_shim_pkg::shim_seg_t [`IGR_PORTS-1:0]  o_seg,
  output logic [`IGR_PORTS-1:0]                     o_seg_v
);
  import igr_shim_pkg::*;

  rx_flit_t s1_rx;
  logic     s1_v;

  // --------------------------------------------------
  // shared s1 stage
  // --------------------------------------------------

  igr_shim_rx_stage u_rx_stage (
    .cclk     (cclk),
    .rst      (rst),
    .i_flit   (i_flit),
    .i_flit_v (i_flit_v),
    .o_rx     (s1_rx),
    .o_rx_v   (s1_v)
  );

  // --------------------------------------------------
  // one packing slice per logical port
  // --------------------------------------------------

  for (genvar p = 0; p < `IGR_PORTS; p++) begin : g_port
    logic                           take;
    logic [$clog2(`IGR_LANES)-1:0]  fill;
    logic [$clog2(`IGR_LANES)+1:0]  sum;
    logic                           wrap;
    logic                           residue;
    logic                           add_en;
    logic                           emit;
    logic                           last;
    logic                           clear;

    assign take = s1_v & s1_rx.port_oh[p];

    igr_shim_fill_counter u_fill (
      .cclk (cclk), .rst (rst), .i_add (s1_rx.count), .i_add_en (add_en),
      .i_clear (clear), .o_fill (fill), .o_sum (sum), .o_wrap (wrap),
      .o_residue (residue)
    );

    igr_shim_frame_fsm u_fsm (
      .cclk (cclk), .rst (rst), .i_take (take), .i_sop (s1_rx.sop),
      .i_eop (s1_rx.eop), .i_wrap (wrap), .i_residue (residue),
      .o_add_en (add_en), .o_emit (emit), .o_last (last), .o_clear (clear)
    );

    igr_shim_seg_pack u_pack (
      .cclk (cclk), .rst (rst), .i_rx (s1_rx), .i_fill (fill), .i_sum (sum),
      .i_add_en (add_en), .i_emit (emit), .i_last (last),
      .o_seg (o_seg[p]), .o_seg_v (o_seg_v[p])
    );
  end

endmodule

// ==== bench/igr_shim_tb.sv ====
`timescale 1ns/1ps
`include "igr_shim_params.svh"

module igr_shim_tb;
  import igr_shim_pkg::*;

  localparam int PORT_W = $clog2(`IGR_PORTS);
  localparam int N_RAND = 40;
  localparam int MAX_RAND_FLITS = 4;
  localparam int DRAIN = 8;
  // directed flits 1+3+2+8, then the random frames at their longest
  localparam int FLIT_COUNT = 14 + N_RAND * MAX_RAND_FLITS;
  // idle after reset, one gap per frame, one drain window per test
  localparam int GAP_COUNT = 10 + (N_RAND + 8) + 6 * DRAIN;
  localparam int TIMEOUT_CYCLES = (FLIT_COUNT + GAP_COUNT) * 2 + 50;

  logic                       cclk;
  logic                       rst;
  epl_flit_t                  i_flit;
  logic                       i_flit_v;
  shim_seg_t [`IGR_PORTS-1:0] o_seg;
  logic [`IGR_PORTS-1:0]      o_seg_v;

  logic [31:0] rng_state = 32'hf1c1;
  int          cycle_cnt = 0;

  // reference packer state with one entry per logical port
  word_t     pend [`IGR_PORTS][$];
  shim_seg_t want_q [`IGR_PORTS][$];
  bit        md_chk_q [`IGR_PORTS][$];
  bit        first_seg [`IGR_PORTS];
  epl_md_u   start_md [`IGR_PORTS];

  igr_shim_top UUT (
    .cclk     (cclk),
    .rst      (rst),
    .i_flit   (i_flit),
    .i_flit_v (i_flit_v),
    .o_seg    (o_seg),
    .o_seg_v  (o_seg_v)
  );

  initial begin
    cclk = 1'b0;
    forever #4 cclk = ~cclk;
  end

  always @(posedge cclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) fail_stop("timeout, the run went past its cycle limit");
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic epl_md_u sop_md();
    epl_md_u     m;
    logic [31:0] r;
    r = next_rand();
    m = '0;
    m.sop.tc = r[2:0];
    m.sop.ts = r[`IGR_TS_W+2:3];
    return m;
  endfunction

  // byte length follows the frame's word count
  function automatic epl_md_u eop_md(input int words);
    epl_md_u     m;
    logic [31:0] r;
    r = next_rand();
    m = '0;
    m.eop.err = r[0];
    m.eop.byte_len = 14'(words * 4);
    return m;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int p = 0; p < `IGR_PORTS; p++) n += want_q[p].size();
    return n;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      fail_stop($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, want));
    end
  endtask

  // --------------------------------------------------
  // reference packer
  // --------------------------------------------------

  task automatic push_expected(input int p, input int n, input bit last, input epl_md_u md);
    shim_seg_t s;
    s = '0;
    for (int i = 0; i < n; i++) s.words[i] = pend[p].pop_front();
    s.count = cnt_t'(n);
    s.sop = first_seg[p];
    s.eop = last;
    s.md = md;
    want_q[p].push_back(s);
    // md is defined only on the first and last segment of a frame
    md_chk_q[p].push_back(first_seg[p] | last);
    first_seg[p] = 1'b0;
  endtask

  task automatic model_flit(input int p, input bit sop, input bit eop, input epl_md_u md);
    if (sop) begin
      first_seg[p] = 1'b1;
      start_md[p] = md;
    end
    if (pend[p].size() > `IGR_LANES || (!eop && pend[p].size() == `IGR_LANES)) begin
      push_expected(p, `IGR_LANES, 1'b0, start_md[p]);
    end
    if (eop) push_expected(p, pend[p].size(), 1'b1, md);
  endtask

  task automatic check_segment(input int p);
    shim_seg_t got;
    shim_seg_t want;
    bit        chk;
    string     tag;
    got = o_seg[p];
    tag = $sformatf("o_seg[%0d]", p);
    if (want_q[p].size() == 0) begin
      fail_stop($sformatf("port %0d put out a segment that was not expected", p));
    end else begin
      want = want_q[p].pop_front();
      chk = md_chk_q[p].pop_front();
      check_eq({tag, ".count"}, 32'(got.count), 32'(want.count));
      check_eq({tag, ".sop"}, 32'(got.sop), 32'(want.sop));
      check_eq({tag, ".eop"}, 32'(got.eop), 32'(want.eop));
      for (int i = 0; i < int'(want.count); i++) begin
        check_eq($sformatf("%s.words[%0d]", tag, i), got.words[i], want.words[i]);
      end
      if (chk) check_eq({tag, ".md"}, 32'(got.md), 32'(want.md));
    end
  endtask

  // outputs only move on the rising edge
  always @(negedge cclk) begin
    if (!rst) begin
      for (int p = 0; p < `IGR_PORTS; p++) begin
        if (o_seg_v[p]) check_segment(p);
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // lanes outside the run carry random words that must be dropped
  task automatic drive_flit(input int p, input bit sop, input bit eop, input int start,
                            input int len, input epl_md_u md);
    epl_flit_t f;
    word_t     w;
    f = '0;
    for (int l = 0; l < `IGR_LANES; l++) begin
      w = next_rand();
      f.words[l] = w;
      if (l >= start && l < start + len) begin
        f.valid_mask[l] = 1'b1;
        pend[p].push_back(w);
      end
    end
    f.port = PORT_W'(p);
    f.sop = sop;
    f.eop = eop;
    f.md = md;
    @(negedge cclk);
    i_flit = f;
    i_flit_v = 1'b1;
    model_flit(p, sop, eop, md);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(negedge cclk);
      i_flit_v = 1'b0;
    end
  endtask

  task automatic wait_seg(input int p);
    int n;
    n = 0;
    do begin
      @(negedge cclk);
      n++;
    end while (!o_seg_v[p] && n < DRAIN);
    if (!o_seg_v[p]) fail_stop($sformatf("no segment appeared on port %0d", p));
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_count() != 0 && n < DRAIN) begin
      @(negedge cclk);
      n++;
    end
    if (pending_count() != 0) fail_stop("expected segments did not appear in time");
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  // a complete start and end flit sits on the bus with its valid low
  task automatic idle_after_reset();
    epl_flit_t f;
    f = '0;
    f.valid_mask = '1;
    f.sop = 1'b1;
    f.eop = 1'b1;
    for (int n = 0; n < 10; n++) begin
      @(negedge cclk);
      f.port = PORT_W'(n);
      i_flit = f;
      i_flit_v = 1'b0;
      check_eq("o_seg_v", 32'(o_seg_v), 32'd0);
    end
  endtask

  task automatic single_full_flit();
    drive_flit(0, 1'b1, 1'b1, 0, 8, sop_md());
    drive_idle(1);
    wait_drain();
  endtask

  // 3 + 8 + 4 words give one full segment then a partial of 7
  task automatic three_flit_frame();
    drive_flit(2, 1'b1, 1'b0, 5, 3, sop_md());
    drive_flit(2, 1'b0, 1'b0, 0, 8, '0);
    drive_flit(2, 1'b0, 1'b1, 0, 4, eop_md(15));
    drive_idle(1);
    wait_drain();
  endtask

  // the leftover 3 of 11 words go out in the gap cycle
  task automatic overflow_flush();
    drive_flit(1, 1'b1, 1'b0, 2, 6, sop_md());
    drive_flit(1, 1'b0, 1'b1, 0, 5, eop_md(11));
    drive_idle(1);
    wait_seg(1);
    @(negedge cclk);
    check_eq("o_seg_v[1]", 32'(o_seg_v[1]), 32'd1);
    check_eq("o_seg[1].eop", 32'(o_seg[1].eop), 32'd1);
    wait_drain();
  endtask

  task automatic interleaved_ports();
    int total [`IGR_PORTS];
    for (int k = 0; k < 2; k++) begin
      for (int p = 0; p < `IGR_PORTS; p++) begin
        if (k == 0) begin
          total[p] = 7 - p;
          drive_flit(p, 1'b1, 1'b0, p + 1, 7 - p, sop_md());
        end else begin
          total[p] += 2 + 2 * p;
          drive_flit(p, 1'b0, 1'b1, 0, 2 + 2 * p, eop_md(total[p]));
        end
      end
    end
    drive_idle(1);
    wait_drain();
  endtask

  task automatic random_frames();
    int          p;
    int          last_p;
    int          nfl;
    int          start;
    int          len;
    int          total;
    epl_md_u     md;
    logic [31:0] r;
    last_p = -1;
    for (int f = 0; f < N_RAND; f++) begin
      p = int'(next_rand() % `IGR_PORTS);
      nfl = 1 + int'(next_rand() % MAX_RAND_FLITS);
      // same port again needs the inter-frame gap
      if (p == last_p) drive_idle(1);
      total = 0;
      for (int k = 0; k < nfl; k++) begin
        start = int'(next_rand() % `IGR_LANES);
        len = 1 + int'(next_rand() % (`IGR_LANES - start));
        total += len;
        r = next_rand();
        md = r[$bits(epl_md_u)-1:0];
        if (k == 0) md = sop_md();
        else if (k == nfl - 1) md = eop_md(total);
        drive_flit(p, k == 0, k == nfl - 1, start, len, md);
      end
      last_p = p;
    end
    drive_idle(1);
    wait_drain();
  endtask

  initial begin
    rst = 1'b1;
    i_flit = '0;
    i_flit_v = 1'b0;
    repeat (3) @(posedge cclk);
    @(negedge cclk);
    rst = 1'b0;
    idle_after_reset();
    single_full_flit();
    three_flit_frame();
    overflow_flush();
    interleaved_ports();
    random_frames();
    // a stray segment after the last frame still reaches the checker
    drive_idle(4);
    if (pending_count() != 0) begin
      fail_stop("expected segments were left over at the end of the run");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== igr_shim_top.f ====
+incdir+include
source/igr_shim_pkg.sv
source/igr_shim_rx_stage.sv
source/igr_shim_fill_counter.sv
source/igr_shim_frame_fsm.sv
source/igr_shim_seg_pack.sv
source/igr_shim_top.sv
bench/igr_shim_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := igr_shim_tb
FILELIST   := igr_shim_top.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
